// ==== src/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN = 32;  // RV32I only

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // Major opcode, instruction bits 6..2
  typedef enum logic [4:0] {
    OP_AI    = 5'b00100,
    OP_AUIPC = 5'b00101,
    OP_A     = 5'b01100,
    OP_LUI   = 5'b01101,
    OP_B     = 5'b11000,
    OP_JALR  = 5'b11001,
    OP_JAL   = 5'b11011
  } opcode_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              dec_load_i,
  input  rv_pkg::word_t     instr_i,
  input  rv_pkg::word_t     pc_i,
  output rv_pkg::word_t     dec_pc_o,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::word_t     imm_o,
  output logic              use_imm_o,
  output logic              op_a_zero_o,
  output logic              op_a_pc_o,
  output logic              rd_wen_o,
  output rv_pkg::alu_op_e   alu_op_o,
  output logic              branch_o,
  output rv_pkg::br_cond_e  br_cond_o,
  output logic              jal_o,
  output logic              jalr_o,
  output logic              illegal_o
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  word_t      imm_i_ext;
  word_t      imm_b_ext;
  word_t      imm_j_ext;
  word_t      imm_u;

  reg_addr_t  rs1_d, rs2_d, rd_d;
  word_t      imm_d;
  alu_op_e    alu_op_d;
  logic       use_imm_d, op_a_zero_d, op_a_pc_d, rd_wen_d;
  logic       branch_d, jal_d, jalr_d, illegal_d;

  assign opcode = opcode_e'(instr_i[6:2]);
  assign funct3 = instr_i[14:12];

  assign imm_i_ext = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_b_ext = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
  assign imm_j_ext = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};
  assign imm_u     = {instr_i[31:12], 12'b0};

  always_comb begin
    rs1_d       = '0;
    rs2_d       = '0;
    rd_d        = '0;
    imm_d       = '0;
    alu_op_d    = ALU_ADD;
    use_imm_d   = 1'b0;
    op_a_zero_d = 1'b0;
    op_a_pc_d   = 1'b0;
    branch_d    = 1'b0;
    jal_d       = 1'b0;
    jalr_d      = 1'b0;
    illegal_d   = 1'b0;
    if (instr_i[1:0] != 2'b11) begin
      illegal_d = 1'b1;  // Compressed encodings not supported
    end else begin
      case (opcode)
        OP_AI: begin
          rs1_d     = instr_i[19:15];
          rd_d      = instr_i[11:7];
          imm_d     = imm_i_ext;
          use_imm_d = 1'b1;
          // Only SRAI keeps the funct7 bit, it is immediate data otherwise
          alu_op_d  = alu_op_e'({instr_i[30] & (funct3 == 3'b101), funct3});
        end
        OP_A: begin
          rs1_d    = instr_i[19:15];
          rs2_d    = instr_i[24:20];
          rd_d     = instr_i[11:7];
          alu_op_d = alu_op_e'({instr_i[30] & (funct3 == 3'b000 || funct3 == 3'b101), funct3});
        end
        OP_LUI: begin
          rd_d        = instr_i[11:7];
          imm_d       = imm_u;
          use_imm_d   = 1'b1;
          op_a_zero_d = 1'b1;  // 0 + imm
        end
        OP_AUIPC: begin
          rd_d      = instr_i[11:7];
          imm_d     = imm_u;
          use_imm_d = 1'b1;
          op_a_pc_d = 1'b1;    // pc + imm
        end
        OP_B: begin
          if (funct3[2:1] == 2'b01) begin
            illegal_d = 1'b1;  // No branch on funct3 010/011
          end else begin
            rs1_d    = instr_i[19:15];
            rs2_d    = instr_i[24:20];
            imm_d    = imm_b_ext;
            branch_d = 1'b1;
          end
        end
        OP_JAL: begin
          rd_d  = instr_i[11:7];
          imm_d = imm_j_ext;
          jal_d = 1'b1;
        end
        OP_JALR: begin
          rs1_d  = instr_i[19:15];
          rd_d   = instr_i[11:7];
          imm_d  = imm_i_ext;
          jalr_d = 1'b1;
        end
        default: illegal_d = 1'b1;
      endcase
    end
    rd_wen_d = (rd_d != '0);  // rd stays zero for non-writing formats
  end

  // Stage flags
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      use_imm_o   <= 1'b0;
      op_a_zero_o <= 1'b0;
      op_a_pc_o   <= 1'b0;
      rd_wen_o    <= 1'b0;
      branch_o    <= 1'b0;
      jal_o       <= 1'b0;
      jalr_o      <= 1'b0;
      illegal_o   <= 1'b0;
    end else if (dec_load_i) begin
      use_imm_o   <= use_imm_d;
      op_a_zero_o <= op_a_zero_d;
      op_a_pc_o   <= op_a_pc_d;
      rd_wen_o    <= rd_wen_d;
      branch_o    <= branch_d;
      jal_o       <= jal_d;
      jalr_o      <= jalr_d;
      illegal_o   <= illegal_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_load_i) begin
      dec_pc_o  <= pc_i;
      rs1_o     <= rs1_d;
      rs2_o     <= rs2_d;
      rd_o      <= rd_d;
      imm_o     <= imm_d;
      alu_op_o  <= alu_op_d;
      br_cond_o <= br_cond_e'(funct3);
    end
  end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o,
  input  logic              we_i,
  input  rv_pkg::reg_addr_t wa_i,
  input  rv_pkg::word_t     wd_i
);
  import rv_pkg::*;

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wa_i != '0) begin
      regs[wa_i] <= wd_i;
    end
  end

  // Reads of x0 always return zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== src/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu (
  input  rv_pkg::alu_op_e op_i,
  input  rv_pkg::word_t   a_i,
  input  rv_pkg::word_t   b_i,
  output rv_pkg::word_t   y_o
);
  import rv_pkg::*;

  logic [4:0] shamt;
  word_t      diff;

  assign shamt = b_i[4:0];
  assign diff  = a_i - b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  y_o = a_i + b_i;
      ALU_SUB:  y_o = diff;
      ALU_SLL:  y_o = a_i << shamt;
      ALU_SLT:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: y_o = {31'b0, a_i < b_i};
      ALU_XOR:  y_o = a_i ^ b_i;
      ALU_SRL:  y_o = a_i >> shamt;
      ALU_SRA:  y_o = word_t'($signed(a_i) >>> shamt);  // Arithmetic shift
      ALU_OR:   y_o = a_i | b_i;
      ALU_AND:  y_o = a_i & b_i;
      default:  y_o = a_i + b_i;
    endcase
  end

endmodule

// ==== src/rv_branch_unit.sv ====
`timescale 1ns/1ns

module rv_branch_unit (
  input  rv_pkg::word_t    pc_i,
  input  rv_pkg::word_t    rs1_data_i,
  input  rv_pkg::word_t    rs2_data_i,
  input  rv_pkg::word_t    imm_i,
  input  logic             branch_i,
  input  rv_pkg::br_cond_e br_cond_i,
  input  logic             jal_i,
  input  logic             jalr_i,
  output rv_pkg::word_t    next_pc_o,
  output rv_pkg::word_t    link_o
);
  import rv_pkg::*;

  logic  taken;
  word_t pc_plus4;
  word_t jalr_sum;

  assign pc_plus4 = pc_i + 32'd4;
  assign jalr_sum = rs1_data_i + imm_i;
  assign link_o   = pc_plus4;

  always_comb begin
    case (br_cond_i)
      BR_EQ:   taken = (rs1_data_i == rs2_data_i);
      BR_NE:   taken = (rs1_data_i != rs2_data_i);
      BR_LT:   taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
      BR_GE:   taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      BR_LTU:  taken = (rs1_data_i < rs2_data_i);
      BR_GEU:  taken = (rs1_data_i >= rs2_data_i);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (jalr_i) begin
      next_pc_o = {jalr_sum[31:1], 1'b0};  // Bit 0 cleared
    end else if (jal_i || (branch_i && taken)) begin
      next_pc_o = pc_i + imm_i;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

endmodule

// ==== src/rv_writeback.sv ====
`timescale 1ns/1ns

module rv_writeback (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              wb_load_i,
  input  rv_pkg::word_t     pc_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              rd_wen_i,
  input  logic              illegal_i,
  input  logic              jump_i,
  input  rv_pkg::word_t     alu_y_i,
  input  rv_pkg::word_t     link_i,
  input  rv_pkg::word_t     next_pc_i,
  output logic              rf_we_o,
  output rv_pkg::reg_addr_t rf_wa_o,
  output rv_pkg::word_t     rf_wd_o,
  output rv_pkg::word_t     res_pc_o,
  output rv_pkg::reg_addr_t res_rd_o,
  output rv_pkg::word_t     res_wdata_o,
  output logic              res_wen_o,
  output rv_pkg::word_t     res_next_pc_o,
  output logic              res_redirect_o,
  output logic              res_illegal_o
);
  import rv_pkg::*;

  word_t wdata;
  logic  redirect;

  assign wdata    = jump_i ? link_i : alu_y_i;  // Jumps write the return address
  assign redirect = (next_pc_i != pc_i + 32'd4);

  // Register file is written on the same edge the result loads
  assign rf_we_o = wb_load_i & rd_wen_i;
  assign rf_wa_o = rd_i;
  assign rf_wd_o = wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_wen_o      <= 1'b0;
      res_redirect_o <= 1'b0;
      res_illegal_o  <= 1'b0;
    end else if (wb_load_i) begin
      res_wen_o      <= rd_wen_i;
      res_redirect_o <= redirect;
      res_illegal_o  <= illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_load_i) begin  // Holds otherwise, covers back-pressure
      res_pc_o      <= pc_i;
      res_rd_o      <= rd_i;
      res_wdata_o   <= wdata;
      res_next_pc_o <= next_pc_i;
    end
  end

endmodule

// ==== src/rv_pipe_ctrl.sv ====
`timescale 1ns/1ns

module rv_pipe_ctrl #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          instr_valid_i,
  output logic          instr_ready_o,
  input  logic          res_ready_i,
  output logic          res_valid_o,
  input  rv_pkg::word_t dec_pc_i,
  input  rv_pkg::word_t next_pc_i,
  output logic          dec_load_o,
  output logic          wb_load_o
);
  import rv_pkg::*;

  typedef enum logic {ST_RESET, ST_RUN} ctrl_state_e;

  ctrl_state_e state_q;
  logic        dec_valid_q;
  logic        wb_valid_q;
  word_t       expected_q;
  word_t       expected_pc;
  logic        wb_free;
  logic        dec_advance;

  // No result retired yet, so the first instruction must sit at RESET_PC
  assign expected_pc = (state_q == ST_RESET) ? RESET_PC : expected_q;

  assign wb_free       = !wb_valid_q || res_ready_i;
  assign dec_advance   = dec_valid_q && wb_free;  // Load or drop
  assign wb_load_o     = dec_advance && (dec_pc_i == expected_pc);
  assign instr_ready_o = !dec_valid_q || dec_advance;
  assign dec_load_o    = instr_valid_i && instr_ready_o;
  assign res_valid_o   = wb_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_RESET;
      dec_valid_q <= 1'b0;
      wb_valid_q  <= 1'b0;
    end else begin
      if (wb_load_o) begin
        state_q <= ST_RUN;
      end
      if (dec_load_o) begin
        dec_valid_q <= 1'b1;
      end else if (dec_advance) begin
        dec_valid_q <= 1'b0;
      end
      if (wb_load_o) begin
        wb_valid_q <= 1'b1;
      end else if (res_ready_i) begin
        wb_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_load_o) begin
      expected_q <= next_pc_i;  // Where the correct path continues
    end
  end

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  output logic              instr_ready_o,
  input  rv_pkg::word_t     instr_i,
  input  rv_pkg::word_t     pc_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output rv_pkg::word_t     res_pc_o,
  output rv_pkg::reg_addr_t res_rd_o,
  output rv_pkg::word_t     res_wdata_o,
  output logic              res_wen_o,
  output rv_pkg::word_t     res_next_pc_o,
  output logic              res_redirect_o,
  output logic              res_illegal_o
);
  import rv_pkg::*;

  logic      dec_load, wb_load;
  word_t     dec_pc, imm, next_pc, link;
  reg_addr_t rs1, rs2, rd;
  logic      use_imm, op_a_zero, op_a_pc, rd_wen;
  logic      branch, jal, jalr, illegal;
  alu_op_e   alu_op;
  br_cond_e  br_cond;
  word_t     rs1_data, rs2_data;
  word_t     alu_a, alu_b, alu_y;
  logic      rf_we;
  reg_addr_t rf_wa;
  word_t     rf_wd;

  // ALU operand select
  assign alu_a = op_a_zero ? '0 : (op_a_pc ? dec_pc : rs1_data);
  assign alu_b = use_imm ? imm : rs2_data;

  rv_pipe_ctrl #(.RESET_PC(RESET_PC)) u_pipe_ctrl (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i), .instr_ready_o(instr_ready_o),
    .res_ready_i(res_ready_i), .res_valid_o(res_valid_o),
    .dec_pc_i(dec_pc), .next_pc_i(next_pc),
    .dec_load_o(dec_load), .wb_load_o(wb_load)
  );

  rv_decode u_decode (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .dec_load_i(dec_load),
    .instr_i(instr_i), .pc_i(pc_i), .dec_pc_o(dec_pc),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
    .use_imm_o(use_imm), .op_a_zero_o(op_a_zero), .op_a_pc_o(op_a_pc),
    .rd_wen_o(rd_wen), .alu_op_o(alu_op), .branch_o(branch),
    .br_cond_o(br_cond), .jal_o(jal), .jalr_o(jalr), .illegal_o(illegal)
  );

  rv_regfile u_regfile (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(rf_we), .wa_i(rf_wa), .wd_i(rf_wd)
  );

  rv_alu u_alu (.op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .y_o(alu_y));

  rv_branch_unit u_branch_unit (
    .pc_i(dec_pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm),
    .branch_i(branch), .br_cond_i(br_cond), .jal_i(jal), .jalr_i(jalr),
    .next_pc_o(next_pc), .link_o(link)
  );

  rv_writeback u_writeback (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .wb_load_i(wb_load),
    .pc_i(dec_pc), .rd_i(rd), .rd_wen_i(rd_wen), .illegal_i(illegal),
    .jump_i(jal | jalr), .alu_y_i(alu_y), .link_i(link), .next_pc_i(next_pc),
    .rf_we_o(rf_we), .rf_wa_o(rf_wa), .rf_wd_o(rf_wd),
    .res_pc_o(res_pc_o), .res_rd_o(res_rd_o), .res_wdata_o(res_wdata_o),
    .res_wen_o(res_wen_o), .res_next_pc_o(res_next_pc_o),
    .res_redirect_o(res_redirect_o), .res_illegal_o(res_illegal_o)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

// ==== verif/rv_core_checker.sv ====
`timescale 1ns/1ns

module rv_core_checker (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              instr_ready_i,
  input logic              res_valid_i,
  input logic              res_ready_i,
  input rv_pkg::word_t     res_pc_i,
  input rv_pkg::reg_addr_t res_rd_i,
  input rv_pkg::word_t     res_wdata_i,
  input logic              res_wen_i,
  input rv_pkg::word_t     res_next_pc_i,
  input logic              res_redirect_i,
  input logic              res_illegal_i
);

  // Stalled result must not change
  property p_res_stable;
    @(posedge clk_i) disable iff (!rst_n_i)
      res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_pc_i) &&
        $stable(res_rd_i) && $stable(res_wdata_i) && $stable(res_wen_i) &&
        $stable(res_next_pc_i) && $stable(res_redirect_i) && $stable(res_illegal_i);
  endproperty

  property p_ready_after_reset;
    @(posedge clk_i) $rose(rst_n_i) |-> instr_ready_i;
  endproperty

  property p_wen_rd_nonzero;
    @(posedge clk_i) disable iff (!rst_n_i) res_wen_i |-> res_rd_i != '0;
  endproperty

  a_res_stable: assert property (p_res_stable)
    else $error("result payload changed while stalled");
  a_ready_after_reset: assert property (p_ready_after_reset)
    else $error("instr_ready_o low in first cycle after reset");
  a_wen_rd_nonzero: assert property (p_wen_rd_nonzero)
    else $error("res_wen_o set with rd x0");

endmodule

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb;
  import rv_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic      clk_i, rst_n_i;
  logic      instr_valid_i, instr_ready_o, res_valid_o, res_ready_i;
  word_t     instr_i, pc_i, res_pc_o, res_wdata_o, res_next_pc_o;
  reg_addr_t res_rd_o;
  logic      res_wen_o, res_redirect_o, res_illegal_o;

  int    mismatches = 0;
  int    failures = 0;
  bit    timed_out = 1'b0;
  bit    bp_on = 1'b0;  // Random res_ready_i when set
  string test_name = "reset";
  word_t rand_state;
  word_t tb_pc, model_pc;  // Next send PC and the PC the model expects
  word_t shadow [32];

  word_t     send_ins_q[$], send_pc_q[$];
  word_t     exp_pc_q[$], exp_wd_q[$], exp_next_q[$];
  reg_addr_t exp_rd_q[$];
  bit        exp_wen_q[$], exp_redir_q[$], exp_ill_q[$];

  tb_clock_gen u_clock_gen (.clk_o(clk_i));

  rv_core_top #(.RESET_PC(32'h0)) u_rv_core_top (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i), .instr_ready_o(instr_ready_o),
    .instr_i(instr_i), .pc_i(pc_i),
    .res_valid_o(res_valid_o), .res_ready_i(res_ready_i),
    .res_pc_o(res_pc_o), .res_rd_o(res_rd_o), .res_wdata_o(res_wdata_o),
    .res_wen_o(res_wen_o), .res_next_pc_o(res_next_pc_o),
    .res_redirect_o(res_redirect_o), .res_illegal_o(res_illegal_o)
  );

  bind rv_core_top rv_core_checker u_checker (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .instr_ready_i(instr_ready_o),
    .res_valid_i(res_valid_o), .res_ready_i(res_ready_i), .res_pc_i(res_pc_o),
    .res_rd_i(res_rd_o), .res_wdata_i(res_wdata_o), .res_wen_i(res_wen_o),
    .res_next_pc_i(res_next_pc_o), .res_redirect_i(res_redirect_o),
    .res_illegal_i(res_illegal_o)
  );

  function automatic word_t next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  // Instruction encoders
  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, opcode_e opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_A, 2'b11};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, opcode_e opc);
    return {imm, rd, opc, 2'b11};
  endfunction

  function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_B, 2'b11};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL, 2'b11};
  endfunction

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Reference model for one retired instruction
  task automatic model_step(word_t ins, word_t pc);
    logic [2:0] f3;
    reg_addr_t  rd;
    word_t      a, b, imm, res, nxt;
    bit         wen, ill;
    f3  = ins[14:12];
    rd  = ins[11:7];
    a   = shadow[ins[19:15]];
    b   = shadow[ins[24:20]];
    imm = {{20{ins[31]}}, ins[31:20]};
    nxt = pc + 32'd4;
    res = '0;
    wen = 1'b1;
    ill = (ins[1:0] != 2'b11);
    case (ins[6:2])
      OP_AI:    res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm);
      OP_A:     res = alu_ref(f3, ins[30], a, b);
      OP_LUI:   res = {ins[31:12], 12'b0};
      OP_AUIPC: res = pc + {ins[31:12], 12'b0};
      OP_JAL: begin
        res = nxt;
        nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      OP_JALR: begin
        res = nxt;
        nxt = (a + imm) & ~32'd1;
      end
      OP_B: begin
        wen = 1'b0;
        if (branch_taken(f3, a, b)) begin
          nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      default: ill = 1'b1;
    endcase
    if (ill || !wen) begin
      rd  = '0;
      wen = 1'b0;
    end
    wen = wen && (rd != '0);
    if (wen) shadow[rd] = res;
    model_pc = nxt;
    exp_pc_q.push_back(pc);
    exp_rd_q.push_back(rd);
    exp_wd_q.push_back(res);
    exp_wen_q.push_back(wen);
    exp_next_q.push_back(nxt);
    exp_redir_q.push_back(nxt != pc + 32'd4);
    exp_ill_q.push_back(ill);
  endtask

  task automatic issue(word_t ins);
    send_ins_q.push_back(ins);
    send_pc_q.push_back(tb_pc);
    if (tb_pc == model_pc) model_step(ins, tb_pc);  // Dropped by the DUT when off path
    tb_pc = tb_pc + 32'd4;
  endtask

  task automatic check_word(string what, word_t exp, word_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_reg(string what, reg_addr_t exp, reg_addr_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s %s: expected x%0d actual x%0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(string what, bit exp, logic act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic report_timeout(string what);
    failures++;
    timed_out = 1'b1;
    $display("Timed out in test %s while waiting for %s", test_name, what);
  endtask

  // Starts and returns 1 ns after a rising edge
  task automatic send(word_t ins, word_t pc);
    int waited;
    instr_valid_i = 1'b1;
    instr_i       = ins;
    pc_i          = pc;
    waited        = 0;
    @(negedge clk_i);
    while (!instr_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!instr_ready_o) report_timeout("instr_ready_o");
    @(posedge clk_i);
    #1;
    instr_valid_i = 1'b0;
  endtask

  task automatic send_all();
    while (send_ins_q.size() > 0 && !timed_out) begin
      send(send_ins_q.pop_front(), send_pc_q.pop_front());
    end
  endtask

  task automatic compare_result();
    bit    wen;
    word_t wdata;
    wen   = exp_wen_q.pop_front();
    wdata = exp_wd_q.pop_front();
    check_word("pc", exp_pc_q.pop_front(), res_pc_o);
    check_reg("rd", exp_rd_q.pop_front(), res_rd_o);
    check_flag("wen", wen, res_wen_o);
    if (wen) check_word("wdata", wdata, res_wdata_o);
    check_word("next_pc", exp_next_q.pop_front(), res_next_pc_o);
    check_flag("redirect", exp_redir_q.pop_front(), res_redirect_o);
    check_flag("illegal", exp_ill_q.pop_front(), res_illegal_o);
  endtask

  task automatic receive_n(int n);
    int    got, idle;
    word_t r;
    got  = 0;
    idle = 0;
    while (got < n && idle < TIMEOUT) begin
      r = next_rand();
      res_ready_i = bp_on ? r[0] : 1'b1;
      @(negedge clk_i);
      if (res_valid_o && res_ready_i) begin
        compare_result();
        got++;
        idle = 0;
      end else begin
        idle++;
      end
      @(posedge clk_i);
      #1;
    end
    res_ready_i = 1'b1;
    if (got < n) report_timeout("res_valid_o");
  endtask

  task automatic run_queue();
    if (!timed_out) begin
      fork
        send_all();
        receive_n(exp_pc_q.size());
      join
      repeat (4) begin  // Nothing beyond the expected results
        @(negedge clk_i);
        if (res_valid_o) begin
          failures++;
          $display("Unexpected extra result at pc %h in test %s", res_pc_o, test_name);
        end
        @(posedge clk_i);
        #1;
      end
    end
    send_ins_q.delete();
    send_pc_q.delete();
    exp_pc_q.delete();
    exp_rd_q.delete();
    exp_wd_q.delete();
    exp_wen_q.delete();
    exp_next_q.delete();
    exp_redir_q.delete();
    exp_ill_q.delete();
  endtask

  task automatic test_alu();
    word_t r;
    test_name = "alu";
    r = next_rand();
    issue(enc_i(r[11:0], 5'd0, 3'd0, 5'd1, OP_AI));
    issue(enc_i(r[23:12], 5'd1, 3'd0, 5'd2, OP_AI));  // Depends on x1
    for (int f = 0; f < 8; f++) begin
      issue(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(f + 16)));
    end
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11));  // SUB
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd12));  // SRA
    r = next_rand();
    issue(enc_i({7'h00, r[4:0]}, 5'd1, 3'd1, 5'd13, OP_AI));
    issue(enc_i({7'h00, r[9:5]}, 5'd13, 3'd5, 5'd14, OP_AI));
    issue(enc_i({7'h20, r[14:10]}, 5'd1, 3'd5, 5'd15, OP_AI));
    issue(enc_i(r[31:20], 5'd2, 3'd2, 5'd24, OP_AI));
    issue(enc_i(r[27:16], 5'd2, 3'd3, 5'd25, OP_AI));
    issue(enc_i(r[26:15], 5'd1, 3'd4, 5'd26, OP_AI));
    issue(enc_i(12'd5, 5'd1, 3'd0, 5'd0, OP_AI));      // Write to x0
    issue(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd27));     // x0 still reads zero
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd28));
    run_queue();
  endtask

  task automatic test_upper();
    word_t r;
    test_name = "upper";
    r = next_rand();
    issue(enc_u(r[19:0], 5'd4, OP_LUI));
    issue(enc_u(r[31:12], 5'd5, OP_AUIPC));
    issue(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd6));
    run_queue();
  endtask

  task automatic test_branch();
    br_cond_e   conds [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
    word_t      r;
    logic [11:0] a, b;
    test_name = "branch";
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        r = next_rand();
        a = r[11:0];
        b = (p == 0) ? r[23:12] : r[11:0];
        if (p == 2) begin
          a = 12'hffb;  // Negative against positive
          b = 12'd3;
          if (c >= 4) begin  // Unsigned conditions need the large value second
            a = 12'd3;
            b = 12'hffb;
          end
        end
        issue(enc_i(a, 5'd0, 3'd0, 5'd6, OP_AI));
        issue(enc_i(b, 5'd0, 3'd0, 5'd7, OP_AI));
        issue(enc_b(13'd32, 5'd7, 5'd6, conds[c]));
        issue(enc_i(12'd1, 5'd20, 3'd0, 5'd20, OP_AI));  // Wrong path if taken
        issue(enc_i(12'd2, 5'd20, 3'd0, 5'd20, OP_AI));
        tb_pc = model_pc;
        issue(enc_i(12'd1, 5'd6, 3'd0, 5'd21, OP_AI));   // Target
      end
    end
    run_queue();
  endtask

  task automatic test_jump();
    test_name = "jump";
    issue(enc_j(21'd24, 5'd8));
    issue(enc_i(12'd7, 5'd0, 3'd0, 5'd20, OP_AI));
    issue(enc_i(12'd7, 5'd0, 3'd0, 5'd20, OP_AI));
    tb_pc = model_pc;
    issue(enc_i(12'd13, 5'd8, 3'd0, 5'd9, OP_JALR));   // Odd target has bit 0 dropped
    issue(enc_i(12'd9, 5'd0, 3'd0, 5'd20, OP_AI));
    issue(enc_i(12'd9, 5'd0, 3'd0, 5'd20, OP_AI));
    tb_pc = model_pc;
    issue(enc_i(12'd0, 5'd9, 3'd0, 5'd22, OP_AI));
    issue(enc_j(21'h1ffff8, 5'd0));                    // Backward jump without link
    issue(enc_i(12'd3, 5'd0, 3'd0, 5'd20, OP_AI));
    tb_pc = model_pc;
    issue(enc_i(12'd1, 5'd22, 3'd0, 5'd23, OP_AI));
    run_queue();
  endtask

  task automatic test_backpressure();
    word_t       r;
    logic [11:0] imm;
    test_name = "backpressure";
    bp_on = 1'b1;
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      imm = r[23:12];
      if (r[10:9] == 2'b01) imm = {1'b0, r[24], 5'b0, r[16:12]};  // Shift encodings
      if (r[31]) begin
        issue(enc_i(imm, {2'b00, r[5:3]}, r[11:9], {2'b00, r[2:0]}, OP_AI));
      end else begin
        issue(enc_r({1'b0, r[30] & (r[11:9] == 3'd5 || r[11:9] == 3'd0), 5'b0},
                    {2'b00, r[8:6]}, {2'b00, r[5:3]}, r[11:9], {2'b00, r[2:0]}));
      end
    end
    run_queue();
    bp_on = 1'b0;
  endtask

  task automatic test_illegal();
    test_name = "illegal";
    issue({12'd8, 5'd1, 3'b010, 5'd10, 7'b0000011});        // Load
    issue({7'd0, 5'd2, 5'd1, 3'b010, 5'd4, 7'b0100011});    // Store
    issue(32'h0000_4501);                                    // Compressed
    issue(enc_i(12'd4, 5'd1, 3'd0, 5'd10, OP_AI));
    run_queue();
  endtask

  initial begin
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    res_ready_i   = 1'b1;
    rand_state    = 32'd10583;
    tb_pc         = '0;
    model_pc      = '0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    test_alu();
    test_upper();
    test_branch();
    test_jump();
    test_backpressure();
    test_illegal();
    $display("Run finished with %0d mismatches and %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_branch_unit.sv
src/rv_writeback.sv
src/rv_pipe_ctrl.sv
src/rv_core_top.sv
verif/tb_clock_gen.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim
out=$(./obj_dir/rv_core_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q -F 'All tests passed!'; then
  exit 0
fi
exit 1
